//--- rv_isa_pkg.sv
// RV32IM instruction field types and encodings, imported by the instruction decoders
`default_nettype none

package rv_isa_pkg;

  ////////////////////
  // Field types
  ////////////////////

  // Full instruction word as fetched
  typedef logic [31:0] instr_t;
  // Major opcode, instr[6:0]
  typedef logic [6:0]  opcode_t;
  // Minor operation, instr[14:12]
  typedef logic [2:0]  funct3_t;
  // Upper function field, instr[31:25]
  typedef logic [6:0]  funct7_t;

  ////////////////////
  // Major opcodes
  ////////////////////

  localparam opcode_t OPCODE_OP       = 7'b0110011;
  localparam opcode_t OPCODE_OPIMM    = 7'b0010011;
  localparam opcode_t OPCODE_LOAD     = 7'b0000011;
  localparam opcode_t OPCODE_STORE    = 7'b0100011;
  localparam opcode_t OPCODE_BRANCH   = 7'b1100011;
  localparam opcode_t OPCODE_JAL      = 7'b1101111;
  localparam opcode_t OPCODE_JALR     = 7'b1100111;
  localparam opcode_t OPCODE_LUI      = 7'b0110111;
  localparam opcode_t OPCODE_AUIPC    = 7'b0010111;
  localparam opcode_t OPCODE_SYSTEM   = 7'b1110011;
  localparam opcode_t OPCODE_MISC_MEM = 7'b0001111;
  // A extension is not implemented, so this opcode is kept only to be rejected
  localparam opcode_t OPCODE_AMO      = 7'b0101111;

  // Funct3 codes that the decoders look at individually
  localparam funct3_t FUNCT3_ADD      = 3'b000;
  localparam funct3_t FUNCT3_SLL      = 3'b001;
  localparam funct3_t FUNCT3_SR       = 3'b101;
  localparam funct3_t FUNCT3_JALR     = 3'b000;
  localparam funct3_t FUNCT3_PRIV     = 3'b000;
  localparam funct3_t FUNCT3_CSR_RSV  = 3'b100;
  localparam funct3_t FUNCT3_FENCE    = 3'b000;
  localparam funct3_t FUNCT3_FENCEI   = 3'b001;

  // Funct7 codes, ALT selects SUB and SRA/SRAI
  localparam funct7_t FUNCT7_BASE     = 7'b0000000;
  localparam funct7_t FUNCT7_ALT      = 7'b0100000;
  localparam funct7_t FUNCT7_MULDIV   = 7'b0000001;

  // Privileged instructions are matched on the whole word
  localparam instr_t  INSTR_ECALL     = 32'h0000_0073;
  localparam instr_t  INSTR_EBREAK    = 32'h0010_0073;
  localparam instr_t  INSTR_MRET      = 32'h3020_0073;
  localparam instr_t  INSTR_WFI       = 32'h1050_0073;

endpackage

`default_nettype wire

//--- rv_ctrl_pkg.sv
// Decode control encodings and issue state type, shared by the decoders, issue FSM and top level
`default_nettype none

package rv_ctrl_pkg;

  // Unit enables as {alu, div, mul, csr, sys, lsu, illegal}
  typedef logic [6:0] unit_en_t;

  localparam int UNIT_ALU     = 6;
  localparam int UNIT_DIV     = 5;
  localparam int UNIT_MUL     = 4;
  localparam int UNIT_CSR     = 3;
  localparam int UNIT_SYS     = 2;
  localparam int UNIT_LSU     = 1;
  localparam int UNIT_ILLEGAL = 0;

  localparam unit_en_t UNIT_EN_NONE = 7'b000_0000;

  // Operand source selects, zero always means unused
  typedef logic [1:0] op_a_sel_t;
  localparam op_a_sel_t OP_A_NONE = 2'd0;
  localparam op_a_sel_t OP_A_REG  = 2'd1;
  localparam op_a_sel_t OP_A_PC   = 2'd2;
  localparam op_a_sel_t OP_A_ZERO = 2'd3;

  typedef logic [1:0] op_b_sel_t;
  localparam op_b_sel_t OP_B_NONE = 2'd0;
  localparam op_b_sel_t OP_B_REG  = 2'd1;
  localparam op_b_sel_t OP_B_IMM  = 2'd2;

  // Operand C carries store data or the branch compare operand
  typedef logic op_c_sel_t;
  localparam op_c_sel_t OP_C_NONE = 1'b0;
  localparam op_c_sel_t OP_C_REG  = 1'b1;

  // Issue FSM states
  typedef enum logic {IDLE, WAIT_MULDIV} issue_state_t;

endpackage

`default_nettype wire

//--- rv_i_decoder.sv
// Combinational decoder for the RV32I base set, driving unit enables, operand selects and a match flag
`default_nettype none
`timescale 1ns/1ps

module rv_i_decoder (
  input  rv_isa_pkg::instr_t     instr_i,
  output rv_ctrl_pkg::unit_en_t  unit_en_o,
  output rv_ctrl_pkg::op_a_sel_t op_a_sel_o,
  output rv_ctrl_pkg::op_b_sel_t op_b_sel_o,
  output rv_ctrl_pkg::op_c_sel_t op_c_sel_o,
  output logic                   match_o
);
  import rv_isa_pkg::*;
  import rv_ctrl_pkg::*;

  opcode_t opcode;
  funct3_t funct3;
  funct7_t funct7;

  assign opcode = instr_i[6:0];
  assign funct3 = instr_i[14:12];
  assign funct7 = instr_i[31:25];

  // Every branch sets the match flag together with its controls
  // With no match all outputs keep their idle defaults
  always_comb begin
    unit_en_o  = UNIT_EN_NONE;
    op_a_sel_o = OP_A_NONE;
    op_b_sel_o = OP_B_NONE;
    op_c_sel_o = OP_C_NONE;
    match_o    = 1'b0;
    case (opcode)
      OPCODE_OP: begin
        // Only SUB and SRA use the alternate funct7, MULDIV is left to the M decoder
        if ((funct7 == FUNCT7_BASE) ||
            ((funct7 == FUNCT7_ALT) && ((funct3 == FUNCT3_ADD) || (funct3 == FUNCT3_SR)))) begin
          match_o             = 1'b1;
          unit_en_o[UNIT_ALU] = 1'b1;
          op_a_sel_o          = OP_A_REG;
          op_b_sel_o          = OP_B_REG;
        end
      end
      OPCODE_OPIMM: begin
        // Shift immediates constrain the upper bits, the rest take any immediate
        if (((funct3 != FUNCT3_SLL) && (funct3 != FUNCT3_SR)) ||
            ((funct3 == FUNCT3_SLL) && (funct7 == FUNCT7_BASE)) ||
            ((funct3 == FUNCT3_SR) && ((funct7 == FUNCT7_BASE) || (funct7 == FUNCT7_ALT)))) begin
          match_o             = 1'b1;
          unit_en_o[UNIT_ALU] = 1'b1;
          op_a_sel_o          = OP_A_REG;
          op_b_sel_o          = OP_B_IMM;
        end
      end
      OPCODE_LOAD: begin
        // LB, LH, LW, LBU and LHU
        if (funct3 inside {3'b000, 3'b001, 3'b010, 3'b100, 3'b101}) begin
          match_o             = 1'b1;
          unit_en_o[UNIT_LSU] = 1'b1;
          op_a_sel_o          = OP_A_REG;
          op_b_sel_o          = OP_B_IMM;
        end
      end
      OPCODE_STORE: begin
        // SB, SH and SW, store data rides on operand C
        if (funct3 inside {3'b000, 3'b001, 3'b010}) begin
          match_o             = 1'b1;
          unit_en_o[UNIT_LSU] = 1'b1;
          op_a_sel_o          = OP_A_REG;
          op_b_sel_o          = OP_B_IMM;
          op_c_sel_o          = OP_C_REG;
        end
      end
      OPCODE_BRANCH: begin
        // ALU forms the target from PC and offset, the compare operand comes on C
        if (!(funct3 inside {3'b010, 3'b011})) begin
          match_o             = 1'b1;
          unit_en_o[UNIT_ALU] = 1'b1;
          op_a_sel_o          = OP_A_PC;
          op_b_sel_o          = OP_B_IMM;
          op_c_sel_o          = OP_C_REG;
        end
      end
      OPCODE_JAL: begin
        match_o             = 1'b1;
        unit_en_o[UNIT_ALU] = 1'b1;
        op_a_sel_o          = OP_A_PC;
        op_b_sel_o          = OP_B_IMM;
      end
      OPCODE_JALR: begin
        if (funct3 == FUNCT3_JALR) begin
          match_o             = 1'b1;
          unit_en_o[UNIT_ALU] = 1'b1;
          op_a_sel_o          = OP_A_REG;
          op_b_sel_o          = OP_B_IMM;
        end
      end
      OPCODE_LUI: begin
        // LUI is computed as zero plus the upper immediate
        match_o             = 1'b1;
        unit_en_o[UNIT_ALU] = 1'b1;
        op_a_sel_o          = OP_A_ZERO;
        op_b_sel_o          = OP_B_IMM;
      end
      OPCODE_AUIPC: begin
        match_o             = 1'b1;
        unit_en_o[UNIT_ALU] = 1'b1;
        op_a_sel_o          = OP_A_PC;
        op_b_sel_o          = OP_B_IMM;
      end
      OPCODE_SYSTEM: begin
        if (funct3 == FUNCT3_PRIV) begin
          // Privileged words are checked in full, other encodings stay illegal
          if (instr_i inside {INSTR_ECALL, INSTR_EBREAK, INSTR_MRET, INSTR_WFI}) begin
            match_o             = 1'b1;
            unit_en_o[UNIT_SYS] = 1'b1;
          end
        end else if (funct3 != FUNCT3_CSR_RSV) begin
          // CSR address is the immediate; only the register forms read rs1
          match_o             = 1'b1;
          unit_en_o[UNIT_CSR] = 1'b1;
          op_a_sel_o          = funct3[2] ? OP_A_NONE : OP_A_REG;
          op_b_sel_o          = OP_B_IMM;
        end
      end
      OPCODE_MISC_MEM: begin
        // FENCE and FENCE.I are both handled by the system unit
        if ((funct3 == FUNCT3_FENCE) || (funct3 == FUNCT3_FENCEI)) begin
          match_o             = 1'b1;
          unit_en_o[UNIT_SYS] = 1'b1;
        end
      end
      OPCODE_AMO: begin
        // No A extension here, so an AMO stays unmatched
        match_o = 1'b0;
      end
      default: begin
        match_o = 1'b0;
      end
    endcase
  end

endmodule

`default_nettype wire

//--- rv_m_decoder.sv
// Combinational decoder for the RV32M multiply and divide instructions, with a match flag
`default_nettype none
`timescale 1ns/1ps

module rv_m_decoder (
  input  rv_isa_pkg::instr_t     instr_i,
  output rv_ctrl_pkg::unit_en_t  unit_en_o,
  output rv_ctrl_pkg::op_a_sel_t op_a_sel_o,
  output rv_ctrl_pkg::op_b_sel_t op_b_sel_o,
  output rv_ctrl_pkg::op_c_sel_t op_c_sel_o,
  output logic                   match_o
);
  import rv_isa_pkg::*;
  import rv_ctrl_pkg::*;

  // Only register-register OP words with the MULDIV funct7 belong here
  assign match_o = (instr_i[6:0] == OPCODE_OP) && (instr_i[31:25] == FUNCT7_MULDIV);

  // Funct3 bit 2 splits MUL/MULH* from DIV/REM*
  always_comb begin
    unit_en_o  = UNIT_EN_NONE;
    op_a_sel_o = OP_A_NONE;
    op_b_sel_o = OP_B_NONE;
    op_c_sel_o = OP_C_NONE;
    if (match_o) begin
      if (instr_i[14]) begin
        unit_en_o[UNIT_DIV] = 1'b1;
        op_a_sel_o          = OP_A_REG;
        op_b_sel_o          = OP_B_REG;
      end else begin
        // Multiplier reads the register file itself, so no operand selects
        unit_en_o[UNIT_MUL] = 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

//--- rv_decoder.sv
// Decoder wrapper that merges the I and M sub-decoders, masks pointer words and registers controls
`default_nettype none
`timescale 1ns/1ps

module rv_decoder (
  input  logic                   clk,
  input  logic                   rst_i,
  input  logic                   accept_i,
  input  rv_isa_pkg::instr_t     instr_i,
  input  logic                   ptr_i,
  output rv_ctrl_pkg::unit_en_t  unit_en_next_o,
  output rv_ctrl_pkg::unit_en_t  unit_en_o,
  output rv_ctrl_pkg::op_a_sel_t op_a_sel_o,
  output rv_ctrl_pkg::op_b_sel_t op_b_sel_o,
  output rv_ctrl_pkg::op_c_sel_t op_c_sel_o,
  output logic                   issue_o
);
  import rv_ctrl_pkg::*;

  unit_en_t  i_unit_en, m_unit_en, dec_unit_en;
  op_a_sel_t i_op_a_sel, m_op_a_sel, dec_op_a_sel;
  op_b_sel_t i_op_b_sel, m_op_b_sel, dec_op_b_sel;
  op_c_sel_t i_op_c_sel, m_op_c_sel, dec_op_c_sel;
  logic      i_match, m_match;
  logic      issue_q;

  rv_i_decoder rv_i_decoder_inst (
    .instr_i    (instr_i),
    .unit_en_o  (i_unit_en),
    .op_a_sel_o (i_op_a_sel),
    .op_b_sel_o (i_op_b_sel),
    .op_c_sel_o (i_op_c_sel),
    .match_o    (i_match)
  );

  rv_m_decoder rv_m_decoder_inst (
    .instr_i    (instr_i),
    .unit_en_o  (m_unit_en),
    .op_a_sel_o (m_op_a_sel),
    .op_b_sel_o (m_op_b_sel),
    .op_c_sel_o (m_op_c_sel),
    .match_o    (m_match)
  );

  ////////////////////
  // Merge
  ////////////////////

  // The sub-decoders never match the same word, so the priority order is arbitrary
  // A pointer word is data, it gets no unit and is not illegal either
  always_comb begin
    dec_unit_en  = UNIT_EN_NONE;
    dec_op_a_sel = OP_A_NONE;
    dec_op_b_sel = OP_B_NONE;
    dec_op_c_sel = OP_C_NONE;
    if (!ptr_i) begin
      if (m_match) begin
        dec_unit_en  = m_unit_en;
        dec_op_a_sel = m_op_a_sel;
        dec_op_b_sel = m_op_b_sel;
        dec_op_c_sel = m_op_c_sel;
      end else if (i_match) begin
        dec_unit_en  = i_unit_en;
        dec_op_a_sel = i_op_a_sel;
        dec_op_b_sel = i_op_b_sel;
        dec_op_c_sel = i_op_c_sel;
      end else begin
        dec_unit_en[UNIT_ILLEGAL] = 1'b1;
      end
    end
  end

  // Issue FSM needs the unregistered enables to start the multiply/divide timer
  assign unit_en_next_o = dec_unit_en;

  ////////////////////
  // Issue register
  ////////////////////

  // Enables and the issue strobe are control state and are cleared by reset
  always_ff @(posedge clk) begin
    if (rst_i) begin
      issue_q   <= 1'b0;
      unit_en_o <= UNIT_EN_NONE;
    end else begin
      issue_q <= accept_i;
      if (accept_i) begin
        unit_en_o <= dec_unit_en;
      end
    end
  end

  // Operand selects hold their last value between issues
  always_ff @(posedge clk) begin
    if (accept_i) begin
      op_a_sel_o <= dec_op_a_sel;
      op_b_sel_o <= dec_op_b_sel;
      op_c_sel_o <= dec_op_c_sel;
    end
  end

  assign issue_o = issue_q;

endmodule

`default_nettype wire

//--- rv_issue_fsm.sv
// Issue FSM that accepts decoded instructions and stalls the stage while a multiply or divide runs
`default_nettype none
`timescale 1ns/1ps

module rv_issue_fsm (
  input  logic                  clk,
  input  logic                  rst_i,
  input  logic                  instr_valid_i,
  input  rv_ctrl_pkg::unit_en_t unit_en_i,
  input  logic                  done_i,
  output logic                  accept_o,
  output logic                  start_mul_o,
  output logic                  start_div_o,
  output logic                  busy_o
);
  import rv_ctrl_pkg::*;

  issue_state_t state_q, state_d;
  logic         busy_q;

  // Acceptance only depends on the state, so a valid word in IDLE is always taken
  assign accept_o    = instr_valid_i && (state_q == IDLE);
  assign start_mul_o = accept_o && unit_en_i[UNIT_MUL];
  assign start_div_o = accept_o && unit_en_i[UNIT_DIV];

  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE: begin
        // Mul and div leave IDLE on the accepting edge
        if (start_mul_o || start_div_o) begin
          state_d = WAIT_MULDIV;
        end
      end
      WAIT_MULDIV: begin
        // The timer flags the last busy cycle
        if (done_i) begin
          state_d = IDLE;
        end
      end
      default: begin
        state_d = IDLE;
      end
    endcase
  end

  // Busy is registered from the next state, so it rises on the accepting edge
  always_ff @(posedge clk) begin
    if (rst_i) begin
      state_q <= IDLE;
      busy_q  <= 1'b0;
    end else begin
      state_q <= state_d;
      busy_q  <= (state_d == WAIT_MULDIV);
    end
  end

  assign busy_o = busy_q;

endmodule

`default_nettype wire

//--- rv_muldiv_timer.sv
// Down counter that times the fixed multiply or divide latency and flags its last cycle
`default_nettype none
`timescale 1ns/1ps

module rv_muldiv_timer #(
  parameter int unsigned MUL_CYCLES = 2,
  parameter int unsigned DIV_CYCLES = 8
) (
  input  logic clk,
  input  logic rst_i,
  input  logic start_mul_i,
  input  logic start_div_i,
  output logic done_o
);
  // Four bits cover latencies from 1 to 15
  typedef logic [3:0] lat_cnt_t;

  // Loading latency minus one makes done land in the last busy cycle
  localparam lat_cnt_t MUL_LOAD = lat_cnt_t'(MUL_CYCLES - 1);
  localparam lat_cnt_t DIV_LOAD = lat_cnt_t'(DIV_CYCLES - 1);

  lat_cnt_t cnt_q;
  logic     run_q;

  assign done_o = run_q && (cnt_q == '0);

  always_ff @(posedge clk) begin
    if (rst_i) begin
      run_q <= 1'b0;
      cnt_q <= '0;
    end else if (start_mul_i) begin
      run_q <= 1'b1;
      cnt_q <= MUL_LOAD;
    end else if (start_div_i) begin
      run_q <= 1'b1;
      cnt_q <= DIV_LOAD;
    end else if (done_o) begin
      run_q <= 1'b0;
    end else if (run_q) begin
      cnt_q <= cnt_q - 1'b1;
    end
  end

endmodule

`default_nettype wire

//--- rv_decode_top.sv
// Top level of the decode stage, connecting the decoder, the issue FSM and the latency timer
`default_nettype none
`timescale 1ns/1ps

module rv_decode_top #(
  parameter int unsigned MUL_CYCLES = 2,
  parameter int unsigned DIV_CYCLES = 8
) (
  input  logic                   clk,
  input  logic                   rst_i,
  input  logic                   instr_valid_i,
  input  rv_isa_pkg::instr_t     instr_i,
  input  logic                   ptr_i,
  output logic                   busy_o,
  output logic                   issue_o,
  output rv_ctrl_pkg::unit_en_t  unit_en_o,
  output rv_ctrl_pkg::op_a_sel_t op_a_sel_o,
  output rv_ctrl_pkg::op_b_sel_t op_b_sel_o,
  output rv_ctrl_pkg::op_c_sel_t op_c_sel_o
);
  import rv_ctrl_pkg::*;

  unit_en_t unit_en_next;
  logic     accept;
  logic     start_mul;
  logic     start_div;
  logic     done;

  rv_decoder rv_decoder_inst (
    .clk            (clk),
    .rst_i          (rst_i),
    .accept_i       (accept),
    .instr_i        (instr_i),
    .ptr_i          (ptr_i),
    .unit_en_next_o (unit_en_next),
    .unit_en_o      (unit_en_o),
    .op_a_sel_o     (op_a_sel_o),
    .op_b_sel_o     (op_b_sel_o),
    .op_c_sel_o     (op_c_sel_o),
    .issue_o        (issue_o)
  );

  // FSM sees the decode of the current word before it is registered
  rv_issue_fsm rv_issue_fsm_inst (
    .clk           (clk),
    .rst_i         (rst_i),
    .instr_valid_i (instr_valid_i),
    .unit_en_i     (unit_en_next),
    .done_i        (done),
    .accept_o      (accept),
    .start_mul_o   (start_mul),
    .start_div_o   (start_div),
    .busy_o        (busy_o)
  );

  rv_muldiv_timer #(
    .MUL_CYCLES (MUL_CYCLES),
    .DIV_CYCLES (DIV_CYCLES)
  ) rv_muldiv_timer_inst (
    .clk         (clk),
    .rst_i       (rst_i),
    .start_mul_i (start_mul),
    .start_div_i (start_div),
    .done_o      (done)
  );

endmodule

`default_nettype wire

//--- rv_decode_asserts.sv
// Concurrent checks on the merged decode of rv_decoder, attached by the bind at the end of this file
`default_nettype none
`timescale 1ns/1ps

module rv_decode_asserts (
  input logic                   clk,
  input logic                   rst_i,
  input rv_isa_pkg::instr_t     instr_i,
  input logic                   ptr_i,
  input rv_ctrl_pkg::unit_en_t  unit_en_i,
  input rv_ctrl_pkg::op_a_sel_t op_a_sel_i,
  input rv_ctrl_pkg::op_b_sel_t op_b_sel_i,
  input rv_ctrl_pkg::op_c_sel_t op_c_sel_i
);
  import rv_isa_pkg::*;
  import rv_ctrl_pkg::*;

  // A real instruction word goes to exactly one unit, or is flagged illegal alone
  a_en_onehot : assert property (@(posedge clk) disable iff (rst_i)
    !ptr_i |-> $onehot(unit_en_i))
    else $error("Unit enables are not one-hot for an instruction word");

  // Pointer words are data, so nothing may be enabled or selected for them
  a_ptr_idle : assert property (@(posedge clk) disable iff (rst_i)
    ptr_i |-> ((unit_en_i == '0) && (op_a_sel_i == OP_A_NONE) &&
               (op_b_sel_i == OP_B_NONE) && (op_c_sel_i == OP_C_NONE)))
    else $error("Pointer word produced an enable or an operand select");

  // The A extension is absent, so every AMO must come out illegal
  a_amo_illegal : assert property (@(posedge clk) disable iff (rst_i)
    (!ptr_i && (instr_i[6:0] == OPCODE_AMO)) |-> unit_en_i[UNIT_ILLEGAL])
    else $error("AMO opcode was not decoded as illegal");

  // Operand A feeds only the ALU, the divider, the CSR unit and address generation
  a_op_a_users : assert property (@(posedge clk) disable iff (rst_i)
    (op_a_sel_i != OP_A_NONE) |->
      (unit_en_i[UNIT_ALU] || unit_en_i[UNIT_DIV] || unit_en_i[UNIT_CSR] || unit_en_i[UNIT_LSU]))
    else $error("Operand A selected for a unit that does not read it");

  // Operand C is branch compare data or store data
  a_op_c_users : assert property (@(posedge clk) disable iff (rst_i)
    (op_c_sel_i != OP_C_NONE) |->
      (unit_en_i[UNIT_ALU] || (unit_en_i[UNIT_LSU] && (instr_i[6:0] == OPCODE_STORE))))
    else $error("Operand C selected outside branches and stores");

endmodule

bind rv_decoder rv_decode_asserts rv_decode_asserts_inst (
  .clk        (clk),
  .rst_i      (rst_i),
  .instr_i    (instr_i),
  .ptr_i      (ptr_i),
  .unit_en_i  (unit_en_next_o),
  .op_a_sel_i (dec_op_a_sel),
  .op_b_sel_i (dec_op_b_sel),
  .op_c_sel_i (dec_op_c_sel)
);

`default_nettype wire

//--- tb_rv_decode.sv
// Testbench for the decode stage, replaying rv_decode_stimulus.txt and checking every DUT output
`default_nettype none
`timescale 1ns/1ps

module tb_rv_decode;
  import rv_isa_pkg::*;
  import rv_ctrl_pkg::*;

  localparam int unsigned MUL_CYCLES   = 2;
  localparam int unsigned DIV_CYCLES   = 8;
  localparam int          CLK_PERIOD   = 100;
  localparam int          RESET_CYCLES = 5;
  localparam int          MAX_LINES    = 32;
  // Words per stimulus line: word, pointer, gap, enables, A, B and C selects
  localparam int          COLS         = 7;
  // An impossible pointer flag closes the stimulus file
  localparam logic [31:0] END_MARK     = 32'hf;
  localparam logic [31:0] SEED         = 32'he735_9589;

  logic      clk;
  logic      rst;
  logic      instr_valid;
  instr_t    instr;
  logic      ptr;
  logic      busy;
  logic      issue;
  unit_en_t  unit_en;
  op_a_sel_t op_a_sel;
  op_b_sel_t op_b_sel;
  op_c_sel_t op_c_sel;

  logic [31:0] stim_mem [0:MAX_LINES*COLS-1];
  int          n_lines     = 0;
  bit          stim_loaded = 1'b0;
  bit          running     = 1'b0;

  ////////////////////
  // Reference model
  ////////////////////

  // Expected controls of the word currently presented to the DUT
  unit_en_t  cur_en;
  op_a_sel_t cur_a;
  op_b_sel_t cur_b;
  op_c_sel_t cur_c;
  // Expected outputs for the cycle after the next rising edge
  unit_en_t  exp_en;
  op_a_sel_t exp_a;
  op_b_sel_t exp_b;
  op_c_sel_t exp_c;
  bit        exp_issue   = 1'b0;
  bit        accept_next = 1'b0;
  // Cycles of busy still ahead, counted from the current cycle
  int        busy_left   = 0;

  rv_decode_top #(
    .MUL_CYCLES (MUL_CYCLES),
    .DIV_CYCLES (DIV_CYCLES)
  ) rv_decode_top_inst (
    .clk           (clk),
    .rst_i         (rst),
    .instr_valid_i (instr_valid),
    .instr_i       (instr),
    .ptr_i         (ptr),
    .busy_o        (busy),
    .issue_o       (issue),
    .unit_en_o     (unit_en),
    .op_a_sel_o    (op_a_sel),
    .op_b_sel_o    (op_b_sel),
    .op_c_sel_o    (op_c_sel)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("ERRORS FOUND");
    $fatal(1, "Simulation stopped after a failure");
  endtask

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected) begin
      abort_run($sformatf("ERROR at %0d ns: %s is %0h, expected %0h",
                          $time, name, actual, expected));
    end
  endtask

  // Only the multiplier and the divider stall the stage
  function automatic int expected_busy_cycles(input unit_en_t en);
    if (en[UNIT_MUL]) begin
      return MUL_CYCLES;
    end
    if (en[UNIT_DIV]) begin
      return DIV_CYCLES;
    end
    return 0;
  endfunction

  // Outputs are settled at the falling edge, so this checks the cycle just past
  // and then predicts what the next rising edge will do
  always @(negedge clk) begin
    if (running) begin
      check_value("issue_o", issue, exp_issue);
      check_value("busy_o", busy, busy_left != 0);
      if (exp_issue) begin
        check_value("unit_en_o", unit_en, exp_en);
        check_value("op_a_sel_o", op_a_sel, exp_a);
        check_value("op_b_sel_o", op_b_sel, exp_b);
        check_value("op_c_sel_o", op_c_sel, exp_c);
      end
      // A word is taken on an edge only while the stage is not busy
      accept_next = instr_valid && (busy_left == 0);
      exp_issue   = accept_next;
      if (busy_left != 0) begin
        busy_left = busy_left - 1;
      end else if (accept_next) begin
        exp_en    = cur_en;
        exp_a     = cur_a;
        exp_b     = cur_b;
        exp_c     = cur_c;
        busy_left = expected_busy_cycles(cur_en);
      end
    end
  end

  // Presents one stimulus line and returns on the edge that accepts it
  task automatic present_line(input int idx);
    int          base;
    int unsigned gap;
    int unsigned extra;
    base  = idx * COLS;
    gap   = stim_mem[base + 2];
    extra = $urandom % 3;
    // A zero gap asks for back-to-back issue, so it gets no random idle cycles
    if (gap != 0) begin
      gap = gap + extra;
    end
    repeat (gap) begin
      instr_valid <= 1'b0;
      @(posedge clk);
    end
    instr       <= stim_mem[base];
    ptr         <= stim_mem[base + 1][0];
    instr_valid <= 1'b1;
    cur_en = unit_en_t'(stim_mem[base + 3]);
    cur_a  = op_a_sel_t'(stim_mem[base + 4]);
    cur_b  = op_b_sel_t'(stim_mem[base + 5]);
    cur_c  = op_c_sel_t'(stim_mem[base + 6]);
    // The word is held while the stage is busy
    @(posedge clk);
    while (!accept_next) begin
      @(posedge clk);
    end
  endtask

  // Watchdog sized from the number of stimulus lines
  initial begin
    wait (stim_loaded);
    #(CLK_PERIOD * (n_lines * (DIV_CYCLES + 6) + RESET_CYCLES));
    abort_run("Timeout: the stimulus did not finish in the allowed number of cycles");
  end

  initial begin
    void'($urandom(SEED));
    rst         = 1'b1;
    instr_valid = 1'b0;
    instr       = '0;
    ptr         = 1'b0;
    $readmemh("rv_decode_stimulus.txt", stim_mem);
    while ((n_lines < MAX_LINES) && (stim_mem[n_lines * COLS + 1] != END_MARK)) begin
      n_lines++;
    end
    if (n_lines == MAX_LINES) begin
      abort_run("Stimulus file has no end marker line");
    end
    if (n_lines == 0) begin
      abort_run("Stimulus file holds no instruction lines");
    end
    stim_loaded = 1'b1;

    repeat (RESET_CYCLES) @(posedge clk);
    rst     <= 1'b0;
    running = 1'b1;

    for (int i = 0; i < n_lines; i++) begin
      present_line(i);
    end
    instr_valid <= 1'b0;
    // Let the last issue and any busy period run out under the monitor
    repeat (DIV_CYCLES + 2) @(posedge clk);
    $display("NO ERRORS");
    $finish;
  end

endmodule

`default_nettype wire

//--- rv_decode_stimulus.txt
// Columns: instruction word, pointer flag, idle cycles before it, expected enables
// {alu,div,mul,csr,sys,lsu,illegal}, operand A select, operand B select, operand C select
003100b3 0 1 40 1 1 0  // add x1, x2, x3
00510093 0 0 40 1 2 0  // addi x1, x2, 5
00812283 0 0 02 1 2 0  // lw x5, 8(x2)
00512623 0 1 02 1 2 1  // sw x5, 12(x2)
00208463 0 2 40 2 2 1  // beq x1, x2, +8
010000ef 0 1 40 2 2 0  // jal x1, +16
123451b7 0 1 40 3 2 0  // lui x3, 0x12345
00001217 0 1 40 2 2 0  // auipc x4, 1
02208333 0 1 10 0 0 0  // mul x6, x1, x2
003100b3 0 0 40 1 1 0  // add held behind the multiply
0220c3b3 0 2 20 1 1 0  // div x7, x1, x2
0220b433 0 0 10 0 0 0  // mulhu held behind the divide
0220e4b3 0 0 20 1 1 0  // rem held behind the multiply
300110f3 0 1 08 1 2 0  // csrrw x1, mstatus, x2
3002e0f3 0 0 08 0 2 0  // csrrsi x1, mstatus, 5
00000073 0 1 04 0 0 0  // ecall
00100073 0 0 04 0 0 0  // ebreak
30200073 0 0 04 0 0 0  // mret
10500073 0 1 04 0 0 0  // wfi
0000100f 0 0 04 0 0 0  // fence.i
0021a0af 0 1 01 0 0 0  // amoadd.w x1, x2, (x3)
0000007f 0 0 01 0 0 0  // unknown opcode
203100b3 0 1 01 0 0 0  // add with a bad funct7
0220c3b3 1 1 00 0 0 0  // div word flagged as a pointer
0021a0af 1 0 00 0 0 0  // AMO word flagged as a pointer
403100b3 0 2 40 1 1 0  // sub x1, x2, x3
40315093 0 0 40 1 2 0  // srai x1, x2, 3
000100e7 0 0 40 1 2 0  // jalr x1, 0(x2)
ffffffff f f ff f f f  // end marker

//--- tb.f
rv_isa_pkg.sv
rv_ctrl_pkg.sv
rv_i_decoder.sv
rv_m_decoder.sv
rv_decoder.sv
rv_issue_fsm.sv
rv_muldiv_timer.sv
rv_decode_top.sv
rv_decode_asserts.sv
tb_rv_decode.sv

//--- run.sh
#!/usr/bin/env bash
# Builds the decode stage testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")"
if [ $? -ne 0 ]; then
  echo "Cannot enter the project directory"
  exit 1
fi

LOG=sim.log

verilator --binary --assert --top-module tb_rv_decode -f tb.f -o sim_tb_rv_decode
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/sim_tb_rv_decode > "$LOG" 2>&1
run_status=$?
cat "$LOG"

if grep -qx "ERRORS FOUND" "$LOG"; then
  echo "Simulation failed"
  exit 1
fi
if [ $run_status -ne 0 ]; then
  echo "Simulation exited with status $run_status"
  exit 1
fi
if ! grep -qx "NO ERRORS" "$LOG"; then
  echo "Simulation ended without a result"
  exit 1
fi
echo "Simulation passed"
exit 0
